// File: Bender.yml
package:
  name: axi_sim_responder

sources:
  - include_dirs:
      - hw
    files:
      - hw/axi_sim_pkg.sv
      - hw/latency_timer.sv
      - hw/read_channel_fsm.sv
      - hw/write_channel_fsm.sv
      - hw/uart_capture.sv
      - hw/axi_sim_responder.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_axi_sim_responder.sv

// File: hw/axi_sim_params.svh
// latency, width and address constants for the simulated AXI slave
// read word returned on every read, console offset and decode width

`ifndef AXI_SIM_PARAMS_SVH
`define AXI_SIM_PARAMS_SVH

// wait in cycles between address accept and response
`define SIM_READ_LATENCY 5
`define SIM_WRITE_LATENCY 5

// fixed read payload
`define SIM_READ_WORD 32'hFFFF_FF21

// console byte sink, matched on the low address bits only
`define UART_ADDR 4096
`define UART_DECODE_BITS 14

// bus and counter widths
`define SIM_ADDR_W 32
`define SIM_DATA_W 32
`define SIM_TIMER_W 4

`endif

// File: hw/axi_sim_pkg.sv
// shared types for the simulated AXI slave
// bus vectors, console byte, countdown value and channel FSM states

`default_nettype none

`include "axi_sim_params.svh"

package axi_sim_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus and payload vectors
    typedef logic [`SIM_ADDR_W-1:0] addr_t;
    typedef logic [`SIM_DATA_W-1:0] data_t;

    // one console character
    typedef logic [7:0] uart_byte_t;

    // countdown value held by each latency timer
    typedef logic [`SIM_TIMER_W-1:0] timer_t;

    //////////////////////////////////////////////////////////////////////
    // channel FSMs
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_RESP
    } read_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_WAIT,
        WR_DATA,
        WR_RESP
    } write_state_t;

endpackage

`default_nettype wire

// File: hw/axi_sim_responder.sv
// top level of the simulated AXI slave
// read and write channel FSMs with their timers, plus console capture

`default_nettype none

`include "axi_sim_params.svh"

module axi_sim_responder
    import axi_sim_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // read address and data
    input  logic       arvalid,
    output logic       arready,
    input  addr_t      araddr,
    output logic       rvalid,
    input  logic       rready,
    output data_t      rdata,
    // write address, data and response
    input  logic       awvalid,
    output logic       awready,
    input  addr_t      awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  data_t      wdata,
    output logic       bvalid,
    input  logic       bready,
    // console
    output logic       write_uart,
    output uart_byte_t uart_byte
);

    logic rd_timer_load;
    logic rd_timer_zero;
    logic wr_timer_load;
    logic wr_timer_zero;
    logic aw_fire;
    logic w_fire;

    //////////////////////////////////////////////////////////////////////
    // read side, araddr unused since every read returns the same word
    read_channel_fsm u_read_fsm (
        .clk        (clk),
        .rst        (rst),
        .arvalid    (arvalid),
        .rready     (rready),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .timer_load (rd_timer_load),
        .timer_zero (rd_timer_zero)
    );

    latency_timer #(
        .LATENCY (`SIM_READ_LATENCY)
    ) rd_timer (
        .clk  (clk),
        .rst  (rst),
        .load (rd_timer_load),
        .zero (rd_timer_zero)
    );

    //////////////////////////////////////////////////////////////////////
    // write side, independent of the read side
    write_channel_fsm u_write_fsm (
        .clk        (clk),
        .rst        (rst),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .bready     (bready),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .aw_fire    (aw_fire),
        .w_fire     (w_fire),
        .timer_load (wr_timer_load),
        .timer_zero (wr_timer_zero)
    );

    latency_timer #(
        .LATENCY (`SIM_WRITE_LATENCY)
    ) wr_timer (
        .clk  (clk),
        .rst  (rst),
        .load (wr_timer_load),
        .zero (wr_timer_zero)
    );

    // console sink
    uart_capture u_uart_capture (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (awaddr),
        .aw_fire    (aw_fire),
        .wdata      (wdata),
        .w_fire     (w_fire),
        .write_uart (write_uart),
        .uart_byte  (uart_byte)
    );

endmodule

`default_nettype wire

// File: hw/latency_timer.sv
// reloadable countdown timer
// load sets the count to LATENCY, zero flags an expired count

`default_nettype none

`include "axi_sim_params.svh"

module latency_timer
    import axi_sim_pkg::*;
#(
    parameter int LATENCY = `SIM_READ_LATENCY
) (
    input  logic clk,
    input  logic rst,
    input  logic load,
    output logic zero
);

    timer_t count;

    // reload wins over the decrement
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= timer_t'(LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // level, stays high until the next load
    assign zero = (count == '0);

    // owner FSM only reloads an idle timer
    // a reload mid count would stretch the previous wait
    a_load_when_idle : assert property (
        @(posedge clk) disable iff (rst)
        load |-> (count == '0)
    ) else $error("timer reloaded while still counting");

endmodule

`default_nettype wire

// File: hw/read_channel_fsm.sv
// read channel FSM for the simulated slave
// accepts one address, waits on its timer, presents the fixed read word

`default_nettype none

`include "axi_sim_params.svh"

module read_channel_fsm
    import axi_sim_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  arvalid,
    input  logic  rready,
    output logic  arready,
    output logic  rvalid,
    output data_t rdata,
    output logic  timer_load,
    input  logic  timer_zero
);

    read_state_t state;
    read_state_t state_next;

    logic ar_fire;
    logic r_fire;

    // transfers on valid and ready at the same edge
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // start the wait on the address edge itself
    assign timer_load = ar_fire;

    //////////////////////////////////////////////////////////////////////
    // next state
    always_comb begin
        state_next = state;
        case (state)
            RD_IDLE: begin
                if (ar_fire) begin
                    state_next = RD_WAIT;
                end
            end
            RD_WAIT: begin
                // count is already loaded when first seen here
                if (timer_zero) begin
                    state_next = RD_RESP;
                end
            end
            RD_RESP: begin
                if (r_fire) begin
                    state_next = RD_IDLE;
                end
            end
            default: begin
                state_next = RD_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state and handshake outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RD_IDLE;
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else begin
            state   <= state_next;
            // one idle cycle after the response before a new address
            arready <= (state == RD_IDLE) && !ar_fire;
            // held through rready back-pressure
            rvalid  <= (state_next == RD_RESP);
        end
    end

    // read word captured as the wait ends
    always_ff @(posedge clk) begin
        if ((state == RD_WAIT) && timer_zero) begin
            rdata <= `SIM_READ_WORD;
        end
    end

    // only one read in flight
    a_no_addr_during_resp : assert property (
        @(posedge clk) disable iff (rst)
        !(rvalid && arready)
    ) else $error("arready high while a read response is pending");

endmodule

`default_nettype wire

// File: hw/uart_capture.sv
// console capture for the simulated slave
// latches the write address, decodes the console offset,
// emits the written byte with a one-cycle strobe

`default_nettype none

`include "axi_sim_params.svh"

module uart_capture
    import axi_sim_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  addr_t      awaddr,
    input  logic       aw_fire,
    input  data_t      wdata,
    input  logic       w_fire,
    output logic       write_uart,
    output uart_byte_t uart_byte
);

    localparam logic [`UART_DECODE_BITS-1:0] UART_OFFSET = `UART_DECODE_BITS'(`UART_ADDR);

    addr_t aw_addr_q;
    logic  uart_hit;

    // address held for the whole write, bus may change after the aw edge
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_addr_q <= awaddr;
        end
    end

    // upper bits ignored, console aliases every 16 KiB
    assign uart_hit = (aw_addr_q[`UART_DECODE_BITS-1:0] == UART_OFFSET);

    // strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            write_uart <= 1'b0;
        end else begin
            write_uart <= w_fire && uart_hit;
        end
    end

    // low byte only
    always_ff @(posedge clk) begin
        if (w_fire && uart_hit) begin
            uart_byte <= wdata[7:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/write_channel_fsm.sv
// write channel FSM for the simulated slave
// address accept, fixed wait, data accept, then the write response
// pulses aw_fire and w_fire for the console capture

`default_nettype none

`include "axi_sim_params.svh"

module write_channel_fsm
    import axi_sim_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic awvalid,
    input  logic wvalid,
    input  logic bready,
    output logic awready,
    output logic wready,
    output logic bvalid,
    output logic aw_fire,
    output logic w_fire,
    output logic timer_load,
    input  logic timer_zero
);

    write_state_t state;
    write_state_t state_next;

    logic b_fire;

    //////////////////////////////////////////////////////////////////////
    // channel transfers
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    // wait starts on the address edge
    assign timer_load = aw_fire;

    //////////////////////////////////////////////////////////////////////
    // next state
    always_comb begin
        state_next = state;
        case (state)
            WR_IDLE: begin
                if (aw_fire) begin
                    state_next = WR_WAIT;
                end
            end
            WR_WAIT: begin
                if (timer_zero) begin
                    state_next = WR_DATA;
                end
            end
            WR_DATA: begin
                // single beat, response follows at once
                if (w_fire) begin
                    state_next = WR_RESP;
                end
            end
            WR_RESP: begin
                if (b_fire) begin
                    state_next = WR_IDLE;
                end
            end
            default: begin
                state_next = WR_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state and handshake outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= WR_IDLE;
            awready <= 1'b1;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            state   <= state_next;
            // back one cycle after the b transfer
            awready <= (state == WR_IDLE) && !aw_fire;
            // wready falls and bvalid rises on the w transfer edge
            wready  <= (state_next == WR_DATA);
            bvalid  <= (state_next == WR_RESP);
        end
    end

    // data phase and response phase never overlap
    a_data_resp_exclusive : assert property (
        @(posedge clk) disable iff (rst)
        !(wready && bvalid)
    ) else $error("wready and bvalid high together");

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/axi_sim_pkg.sv
hw/latency_timer.sv
hw/read_channel_fsm.sv
hw/write_channel_fsm.sv
hw/uart_capture.sv
hw/axi_sim_responder.sv
test/tb_axi_sim_responder.sv

// File: test/tb_axi_sim_responder.sv
// testbench for the simulated AXI slave
// table of reads and writes applied in a loop, LFSR back-pressure,
// latency, hold and console strobe checks with per-wait timeouts

`default_nettype none

`include "axi_sim_params.svh"

module tb_axi_sim_responder
    import axi_sim_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 50;
    // address edge counts as edge 0
    localparam int READ_EDGES  = `SIM_READ_LATENCY + 1;
    localparam int WRITE_EDGES = `SIM_WRITE_LATENCY + 1;
    localparam int NUM_ROWS    = 8;

    // word every read must return
    localparam data_t READ_WORD = 32'hFFFF_FF21;

    localparam logic [1:0] KIND_READ  = 2'd0;
    localparam logic [1:0] KIND_WRITE = 2'd1;
    localparam logic [1:0] KIND_BOTH  = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [7:0]  wbyte;
        logic [3:0]  hold;
    } row_t;

    // kind, address, write byte, back-pressure cycles
    row_t rows [0:NUM_ROWS-1] = '{
        '{KIND_READ,  32'h0000_0100, 8'h00, 4'd0},
        '{KIND_WRITE, 32'h0000_1000, 8'h48, 4'd0},
        '{KIND_READ,  32'h0000_0200, 8'h00, 4'd3},
        '{KIND_WRITE, 32'h0000_2000, 8'h55, 4'd2},
        '{KIND_WRITE, 32'h0000_5000, 8'h69, 4'd4},
        '{KIND_BOTH,  32'h0000_1000, 8'h21, 4'd1},
        '{KIND_WRITE, 32'h0000_1004, 8'h7a, 4'd0},
        '{KIND_BOTH,  32'h0000_3000, 8'h0a, 4'd2}
    };

    logic       clk;
    logic       rst;
    logic       arvalid;
    logic       arready;
    addr_t      araddr;
    logic       rvalid;
    logic       rready;
    data_t      rdata;
    logic       awvalid;
    logic       awready;
    addr_t      awaddr;
    logic       wvalid;
    logic       wready;
    data_t      wdata;
    logic       bvalid;
    logic       bready;
    logic       write_uart;
    uart_byte_t uart_byte;

    int         errors = 0;
    int         checks = 0;
    logic [7:0] lfsr_state = 8'd42;

    axi_sim_responder uut (
        .clk        (clk),
        .rst        (rst),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .bvalid     (bvalid),
        .bready     (bready),
        .write_uart (write_uart),
        .uart_byte  (uart_byte)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    // 8-bit Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        logic fb;
        fb = s[7] ^ s[5] ^ s[4] ^ s[3];
        return {s[6:0], fb};
    endfunction

    // one LFSR step per bit taken
    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int b = 0; b < count; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    // registered outputs are settled 1 ns after the edge, inputs change here too
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s never arrived within %0d cycles", what, TIMEOUT_CYCLES);
        $display("errors: %0d, checks: %0d", errors + 1, checks);
        $display("TEST FAIL");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // read channel sequence
    task automatic run_read(input logic [31:0] addr, input int hold_cycles);
        int waited;
        int edges;
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b0;
        waited  = 0;
        while (!arready) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT_CYCLES) report_timeout("arready");
        end
        // ar transfer on this edge
        next_cycle();
        arvalid = 1'b0;
        araddr  = '0;
        edges   = 0;
        while (!rvalid) begin
            check_value("arready during read wait", arready, 0);
            next_cycle();
            edges++;
            if (edges > TIMEOUT_CYCLES) report_timeout("rvalid");
        end
        check_value("read latency in edges", edges, READ_EDGES);
        check_value("rdata", rdata, READ_WORD);
        check_value("arready with rvalid", arready, 0);
        // rready back-pressure, response must hold still
        repeat (hold_cycles) begin
            next_cycle();
            check_value("rvalid under back-pressure", rvalid, 1);
            check_value("rdata under back-pressure", rdata, READ_WORD);
            check_value("arready under back-pressure", arready, 0);
        end
        rready = 1'b1;
        next_cycle();
        rready = 1'b0;
        check_value("rvalid after r transfer", rvalid, 0);
        check_value("arready at r transfer", arready, 0);
        next_cycle();
        check_value("arready after r transfer", arready, 1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // write channel sequence with console check
    task automatic run_write(input logic [31:0] addr, input logic [7:0] wbyte,
                             input int hold_cycles, input int data_delay);
        int   waited;
        int   edges;
        int   pulses;
        logic hit;
        // console decode on the low 14 bits
        hit     = (addr[13:0] == 14'd4096);
        pulses  = 0;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b0;
        bready  = 1'b0;
        waited  = 0;
        while (!awready) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT_CYCLES) report_timeout("awready");
        end
        next_cycle();
        if (write_uart) pulses++;
        awvalid = 1'b0;
        // bus address moves away, capture must use the latched one
        awaddr  = addr ^ 32'h0000_1000;
        wdata   = {24'hc3c3c3, wbyte};
        edges   = 0;
        while (!wready) begin
            check_value("awready during write wait", awready, 0);
            check_value("bvalid during write wait", bvalid, 0);
            next_cycle();
            if (write_uart) pulses++;
            edges++;
            if (edges > TIMEOUT_CYCLES) report_timeout("wready");
        end
        check_value("write latency in edges", edges, WRITE_EDGES);
        // wready waits for a late wvalid
        repeat (data_delay) begin
            next_cycle();
            if (write_uart) pulses++;
            check_value("wready before wvalid", wready, 1);
            check_value("bvalid before w transfer", bvalid, 0);
        end
        wvalid = 1'b1;
        next_cycle();
        wvalid = 1'b0;
        wdata  = '0;
        check_value("wready after w transfer", wready, 0);
        check_value("bvalid at w transfer", bvalid, 1);
        check_value("write_uart after w transfer", write_uart, hit);
        if (hit) check_value("uart_byte", uart_byte, wbyte);
        if (write_uart) pulses++;
        repeat (hold_cycles) begin
            next_cycle();
            if (write_uart) pulses++;
            check_value("bvalid under back-pressure", bvalid, 1);
            check_value("awready under back-pressure", awready, 0);
        end
        bready = 1'b1;
        next_cycle();
        if (write_uart) pulses++;
        bready = 1'b0;
        check_value("bvalid after b transfer", bvalid, 0);
        check_value("awready at b transfer", awready, 0);
        next_cycle();
        if (write_uart) pulses++;
        check_value("awready after b transfer", awready, 1);
        check_value("write_uart pulse count", pulses, hit ? 1 : 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    initial begin
        int row_idx;
        int rd_hold;
        int wr_hold;
        int wr_delay;
        rst     = 1'b1;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle values out of reset
        check_value("arready after reset", arready, 1);
        check_value("awready after reset", awready, 1);
        check_value("rvalid after reset", rvalid, 0);
        check_value("wready after reset", wready, 0);
        check_value("bvalid after reset", bvalid, 0);
        check_value("write_uart after reset", write_uart, 0);

        for (row_idx = 0; row_idx < NUM_ROWS; row_idx++) begin
            // extra back-pressure drawn before any fork
            rd_hold  = int'(rows[row_idx].hold) + random_bits(2);
            wr_hold  = int'(rows[row_idx].hold) + random_bits(2);
            wr_delay = random_bits(2);
            case (rows[row_idx].kind)
                KIND_READ: begin
                    run_read(rows[row_idx].addr, rd_hold);
                end
                KIND_WRITE: begin
                    run_write(rows[row_idx].addr, rows[row_idx].wbyte, wr_hold, wr_delay);
                end
                default: begin
                    // both channels started on the same cycle
                    fork
                        run_read(rows[row_idx].addr, rd_hold);
                        run_write(rows[row_idx].addr, rows[row_idx].wbyte, wr_hold, wr_delay);
                    join
                end
            endcase
            next_cycle();
        end

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
